// ==== logic/i2c_pkg.sv ====
// shared definitions for the I2C EEPROM master
// bus phase timing constant, width typedefs and the bus engine state enum

package i2c_pkg;

	// ****************************************
	// timing
	// ****************************************
	localparam int PHASE_DIV = 8;         // clocks per bus half-phase

	// ****************************************
	// widths
	// ****************************************
	typedef logic [6:0] dev_addr_t;       // 7-bit device address
	typedef logic [7:0] word_addr_t;      // address inside the EEPROM
	typedef logic [7:0] byte_t;           // data byte
	typedef logic [2:0] bit_cnt_t;        // bit index within a byte

	// ****************************************
	// bus engine states
	// ****************************************
	typedef enum logic [4:0] {
		BUS_IDLE,
		BUS_START,
		BUS_DEV_LOW,
		BUS_DEV_HIGH,
		BUS_DEV_ACK_LOW,
		BUS_DEV_ACK_HIGH,
		BUS_ADDR_LOW,
		BUS_ADDR_HIGH,
		BUS_ADDR_ACK_LOW,
		BUS_ADDR_ACK_HIGH,
		BUS_WDATA_LOW,
		BUS_WDATA_HIGH,
		BUS_WDATA_ACK_LOW,
		BUS_WDATA_ACK_HIGH,
		BUS_RESTART_LOW,
		BUS_RESTART_HIGH,
		BUS_RDATA_LOW,
		BUS_RDATA_HIGH,
		BUS_NACK_LOW,
		BUS_NACK_HIGH,
		BUS_STOP_LOW,
		BUS_STOP_HIGH
	} bus_state_t;

endpackage

// ==== logic/i2c_phase_timer.sv ====
// free-running bus phase divider
// one phase_tick pulse every PHASE_DIV clocks

module i2c_phase_timer
	import i2c_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	output logic phase_tick
);

	logic [$clog2(PHASE_DIV)-1:0] cnt;    // position within the phase

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			cnt <= '0;
		else if (phase_tick)
			cnt <= '0;
		else
			cnt <= cnt + 1'b1;
	end

	// last clock of the phase
	assign phase_tick = (cnt == $bits(cnt)'(PHASE_DIV - 1));

endmodule

// ==== logic/i2c_cmd_ctrl.sv ====
// command and response channel control
// command latch, write-protect refusal and result hold until taken

module i2c_cmd_ctrl
	import i2c_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       cmd_valid,
	output logic       cmd_ready,
	input  logic       cmd_write,
	input  dev_addr_t  cmd_dev,
	input  word_addr_t cmd_addr,
	input  byte_t      cmd_wdata,
	input  logic       write_protect,
	output logic       resp_valid,
	input  logic       resp_ready,
	output byte_t      resp_rdata,
	output logic       resp_fail,
	output logic       start_req,
	output logic       op_write,
	output dev_addr_t  op_dev,
	output word_addr_t op_addr,
	output byte_t      op_wdata,
	input  logic       op_done,
	input  logic       op_nack,
	input  byte_t      op_rdata
);

	typedef enum logic [1:0] {
		CTRL_READY,
		CTRL_BUSY,
		CTRL_RESP
	} ctrl_state_t;

	ctrl_state_t state;
	logic        accept;

	assign cmd_ready  = (state == CTRL_READY);
	assign resp_valid = (state == CTRL_RESP);
	assign accept     = cmd_valid && cmd_ready;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state     <= CTRL_READY;
			start_req <= 1'b0;
			resp_fail <= 1'b0;
		end
		else
		begin
			start_req <= 1'b0;                    // single pulse
			case (state)
				CTRL_READY:
				begin
					if (accept && cmd_write && write_protect)
					begin
						state     <= CTRL_RESP;     // refused, bus untouched
						resp_fail <= 1'b1;
					end
					else if (accept)
					begin
						state     <= CTRL_BUSY;
						start_req <= 1'b1;
					end
				end
				CTRL_BUSY:
				begin
					if (op_done)
					begin
						state     <= CTRL_RESP;
						resp_fail <= op_nack;
					end
				end
				CTRL_RESP:
				begin
					if (resp_ready)
						state <= CTRL_READY;
				end
				default: state <= CTRL_READY;
			endcase
		end
	end

	// command fields and read result
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			op_write   <= cmd_write;
			op_dev     <= cmd_dev;
			op_addr    <= cmd_addr;
			op_wdata   <= cmd_wdata;
			resp_rdata <= '0;
		end
		else if (state == CTRL_BUSY && op_done)
			resp_rdata <= op_rdata;
	end

	// response must hold while the host stalls
	a_resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
		resp_valid && !resp_ready |=>
			resp_valid && $stable(resp_fail) && $stable(resp_rdata));

endmodule

// ==== logic/i2c_bus_fsm.sv ====
// I2C bus engine
// start, address, data, acknowledge and stop sequencing
// bit counter, transmit shift register and read shift register

module i2c_bus_fsm
	import i2c_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       phase_tick,
	input  logic       start_req,
	input  logic       op_write,
	input  dev_addr_t  op_dev,
	input  word_addr_t op_addr,
	input  byte_t      op_wdata,
	output logic       op_done,
	output logic       op_nack,
	output byte_t      op_rdata,
	output logic       scl,
	output logic       sda_oe,
	input  logic       sda_in
);

	bus_state_t state;
	bit_cnt_t   bit_cnt;        // bit within the current byte
	byte_t      shreg;          // outgoing byte, MSB first
	logic       rd_phase;       // second address phase of a read
	logic       pending;        // start_req seen between ticks
	logic       go;
	logic       last_bit;
	logic       scl_lvl;
	logic       sda_drv;        // 1 pulls SDA low

	assign go       = phase_tick && (state == BUS_IDLE) && (pending || start_req);
	assign last_bit = &bit_cnt;
	assign op_done  = phase_tick && (state == BUS_STOP_HIGH);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			pending <= 1'b0;
		else
			pending <= (pending || start_req) && !go;
	end

	// ****************************************
	// state sequencing
	// ****************************************
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state    <= BUS_IDLE;
			bit_cnt  <= '0;
			rd_phase <= 1'b0;
			op_nack  <= 1'b0;
		end
		else if (phase_tick)
		begin
			case (state)
				BUS_IDLE:
				begin
					if (go)
					begin
						state    <= BUS_START;
						bit_cnt  <= '0;
						rd_phase <= 1'b0;
						op_nack  <= 1'b0;
					end
				end
				BUS_START:       state <= BUS_DEV_LOW;
				BUS_DEV_LOW:     state <= BUS_DEV_HIGH;
				BUS_DEV_HIGH:
				begin
					bit_cnt <= bit_cnt + 1'b1;
					state   <= last_bit ? BUS_DEV_ACK_LOW : BUS_DEV_LOW;
				end
				BUS_DEV_ACK_LOW: state <= BUS_DEV_ACK_HIGH;
				BUS_DEV_ACK_HIGH:
				begin
					if (sda_in)
					begin
						op_nack <= 1'b1;             // no device answered
						state   <= BUS_STOP_LOW;
					end
					else if (rd_phase)
						state <= BUS_RDATA_LOW;
					else
						state <= BUS_ADDR_LOW;
				end
				BUS_ADDR_LOW:    state <= BUS_ADDR_HIGH;
				BUS_ADDR_HIGH:
				begin
					bit_cnt <= bit_cnt + 1'b1;
					state   <= last_bit ? BUS_ADDR_ACK_LOW : BUS_ADDR_LOW;
				end
				BUS_ADDR_ACK_LOW: state <= BUS_ADDR_ACK_HIGH;
				BUS_ADDR_ACK_HIGH:
				begin
					if (sda_in)
					begin
						op_nack <= 1'b1;
						state   <= BUS_STOP_LOW;
					end
					else if (op_write)
						state <= BUS_WDATA_LOW;
					else
					begin
						rd_phase <= 1'b1;            // resend device with read bit
						state    <= BUS_RESTART_LOW;
					end
				end
				BUS_WDATA_LOW:   state <= BUS_WDATA_HIGH;
				BUS_WDATA_HIGH:
				begin
					bit_cnt <= bit_cnt + 1'b1;
					state   <= last_bit ? BUS_WDATA_ACK_LOW : BUS_WDATA_LOW;
				end
				BUS_WDATA_ACK_LOW: state <= BUS_WDATA_ACK_HIGH;
				BUS_WDATA_ACK_HIGH:
				begin
					if (sda_in)
						op_nack <= 1'b1;
					state <= BUS_STOP_LOW;
				end
				BUS_RESTART_LOW:  state <= BUS_RESTART_HIGH;
				BUS_RESTART_HIGH: state <= BUS_DEV_LOW;
				BUS_RDATA_LOW:    state <= BUS_RDATA_HIGH;
				BUS_RDATA_HIGH:
				begin
					bit_cnt <= bit_cnt + 1'b1;
					state   <= last_bit ? BUS_NACK_LOW : BUS_RDATA_LOW;
				end
				BUS_NACK_LOW:     state <= BUS_NACK_HIGH;
				BUS_NACK_HIGH:    state <= BUS_STOP_LOW;
				BUS_STOP_LOW:     state <= BUS_STOP_HIGH;
				BUS_STOP_HIGH:    state <= BUS_IDLE;
				default:          state <= BUS_IDLE;
			endcase
		end
	end

	// shift registers, loaded and shifted at phase ends
	always_ff @(posedge clk)
	begin
		if (phase_tick)
		begin
			case (state)
				BUS_IDLE:          shreg <= {op_dev, 1'b0};
				BUS_DEV_HIGH, BUS_ADDR_HIGH, BUS_WDATA_HIGH:
					shreg <= shreg << 1;
				BUS_DEV_ACK_HIGH:  shreg <= op_addr;
				BUS_ADDR_ACK_HIGH: shreg <= op_write ? op_wdata : {op_dev, 1'b1};
				BUS_RDATA_HIGH:    op_rdata <= {op_rdata[6:0], sda_in};
				default: ;
			endcase
		end
	end

	// ****************************************
	// bus levels per state
	// ****************************************
	always_comb
	begin
		scl_lvl = 1'b1;
		sda_drv = 1'b0;
		case (state)
			BUS_DEV_LOW, BUS_ADDR_LOW, BUS_WDATA_LOW:
			begin
				scl_lvl = 1'b0;
				sda_drv = !shreg[7];
			end
			BUS_DEV_HIGH, BUS_ADDR_HIGH, BUS_WDATA_HIGH:
				sda_drv = !shreg[7];
			BUS_DEV_ACK_LOW, BUS_ADDR_ACK_LOW, BUS_WDATA_ACK_LOW,
			BUS_RESTART_LOW, BUS_RDATA_LOW, BUS_NACK_LOW:
				scl_lvl = 1'b0;                  // SDA released
			BUS_STOP_LOW:
			begin
				scl_lvl = 1'b0;
				sda_drv = 1'b1;
			end
			BUS_START, BUS_RESTART_HIGH:
				sda_drv = 1'b1;                  // falling SDA under high SCL
			default: ;
		endcase
	end

	assign scl = scl_lvl;

	// SDA trails SCL by one clock
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			sda_oe <= 1'b0;
		else
			sda_oe <= sda_drv;
	end

	a_sda_stable: assert property (@(posedge clk) disable iff (!rst_n)
		scl && $past(scl) && (sda_oe != $past(sda_oe)) |->
			state inside {BUS_START, BUS_RESTART_HIGH, BUS_STOP_HIGH});

	a_tick_paced: assert property (@(posedge clk) disable iff (!rst_n)
		(state != BUS_IDLE) && !phase_tick |=> $stable(state));

endmodule

// ==== logic/i2c_eeprom_master.sv ====
// I2C EEPROM master top level
// phase timer, command control and bus engine

module i2c_eeprom_master
	import i2c_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       cmd_valid,
	output logic       cmd_ready,
	input  logic       cmd_write,
	input  dev_addr_t  cmd_dev,
	input  word_addr_t cmd_addr,
	input  byte_t      cmd_wdata,
	input  logic       write_protect,
	output logic       resp_valid,
	input  logic       resp_ready,
	output byte_t      resp_rdata,
	output logic       resp_fail,
	output logic       scl,
	output logic       sda_oe,
	input  logic       sda_in
);

	logic       phase_tick;
	logic       start_req;
	logic       op_write;
	dev_addr_t  op_dev;
	word_addr_t op_addr;
	byte_t      op_wdata;
	logic       op_done;
	logic       op_nack;
	byte_t      op_rdata;

	i2c_phase_timer u_timer (
		.clk        (clk),
		.rst_n      (rst_n),
		.phase_tick (phase_tick)
	);

	i2c_cmd_ctrl u_ctrl (
		.clk           (clk),
		.rst_n         (rst_n),
		.cmd_valid     (cmd_valid),
		.cmd_ready     (cmd_ready),
		.cmd_write     (cmd_write),
		.cmd_dev       (cmd_dev),
		.cmd_addr      (cmd_addr),
		.cmd_wdata     (cmd_wdata),
		.write_protect (write_protect),
		.resp_valid    (resp_valid),
		.resp_ready    (resp_ready),
		.resp_rdata    (resp_rdata),
		.resp_fail     (resp_fail),
		.start_req     (start_req),
		.op_write      (op_write),
		.op_dev        (op_dev),
		.op_addr       (op_addr),
		.op_wdata      (op_wdata),
		.op_done       (op_done),
		.op_nack       (op_nack),
		.op_rdata      (op_rdata)
	);

	i2c_bus_fsm u_bus (
		.clk        (clk),
		.rst_n      (rst_n),
		.phase_tick (phase_tick),
		.start_req  (start_req),
		.op_write   (op_write),
		.op_dev     (op_dev),
		.op_addr    (op_addr),
		.op_wdata   (op_wdata),
		.op_done    (op_done),
		.op_nack    (op_nack),
		.op_rdata   (op_rdata),
		.scl        (scl),
		.sda_oe     (sda_oe),
		.sda_in     (sda_in)
	);

endmodule

// ==== test/i2c_eeprom_model.sv ====
// behavioral I2C EEPROM slave for the testbench
// 256-byte memory at one device address, single-byte write and random read

module i2c_eeprom_model
	import i2c_pkg::*;
#(
	parameter dev_addr_t DEV_ADDR = 7'h50
)
(
	input  logic clk,
	input  logic rst_n,
	input  logic scl,
	input  logic sda,
	output logic sda_rel      // 0 pulls SDA low
);
	timeunit 1ns;
	timeprecision 1ps;

	typedef enum logic [2:0] {
		M_IDLE,
		M_DEV,
		M_ADDR,
		M_DATA,
		M_SEND
	} model_phase_t;

	byte_t        mem [256];
	model_phase_t phase;
	model_phase_t next_phase;   // phase after the ACK clock
	byte_t        shreg;        // receive and transmit byte
	word_addr_t   ptr;          // current word address
	int           bit_cnt;
	logic         acking;       // slave holds ACK for this clock
	logic         scl_q;
	logic         sda_q;

	always @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < 256; i++)
				mem[i] <= byte_t'(i);   // low byte of the address
			phase      <= M_IDLE;
			next_phase <= M_IDLE;
			shreg      <= '0;
			ptr        <= '0;
			bit_cnt    <= 0;
			acking     <= 1'b0;
			scl_q      <= 1'b1;
			sda_q      <= 1'b1;
			sda_rel    <= 1'b1;
		end
		else
		begin
			scl_q <= scl;
			sda_q <= sda;
			if (scl && scl_q && sda_q && !sda)
			begin                       // start or repeated start
				phase   <= M_DEV;
				bit_cnt <= 0;
				acking  <= 1'b0;
				sda_rel <= 1'b1;
			end
			else if (scl && scl_q && !sda_q && sda)
			begin                       // stop
				phase   <= M_IDLE;
				acking  <= 1'b0;
				sda_rel <= 1'b1;
			end
			else if (scl && !scl_q && phase != M_IDLE)
			begin
				if (phase == M_SEND && bit_cnt == 8)
					phase <= M_IDLE;        // master ACK or NACK ends the read
				else if (!acking && bit_cnt < 8)
				begin
					shreg   <= {shreg[6:0], sda};
					bit_cnt <= bit_cnt + 1;
				end
			end
			else if (!scl && scl_q && phase != M_IDLE)
			begin
				if (acking)
				begin                   // end of the ACK clock
					acking  <= 1'b0;
					bit_cnt <= 0;
					phase   <= next_phase;
					if (next_phase == M_SEND)
					begin
						shreg   <= mem[ptr];
						sda_rel <= mem[ptr][7];
					end
					else
						sda_rel <= 1'b1;
				end
				else if (phase == M_SEND)
					sda_rel <= (bit_cnt == 8) ? 1'b1 : shreg[7];
				else if (bit_cnt == 8)
				begin
					case (phase)
						M_DEV:
						begin
							if (shreg[7:1] == DEV_ADDR)
							begin
								acking     <= 1'b1;
								sda_rel    <= 1'b0;
								next_phase <= shreg[0] ? M_SEND : M_ADDR;
							end
							else
								phase <= M_IDLE;    // another device
						end
						M_ADDR:
						begin
							ptr        <= shreg;
							acking     <= 1'b1;
							sda_rel    <= 1'b0;
							next_phase <= M_DATA;
						end
						default:
						begin
							mem[ptr]   <= shreg;
							ptr        <= ptr + 1'b1;
							acking     <= 1'b1;
							sda_rel    <= 1'b0;
							next_phase <= M_DATA;
						end
					endcase
				end
			end
		end
	end

endmodule

// ==== test/tb_i2c_eeprom_master.sv ====
// testbench for the I2C EEPROM master
// clock and reset, wired-AND SDA bus, EEPROM model and directed tests

module tb_i2c_eeprom_master
	import i2c_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam dev_addr_t MODEL_DEV   = 7'h50;
	localparam dev_addr_t MISSING_DEV = 7'h51;
	localparam int        TIMEOUT     = 2000;   // clocks per wait
	localparam int        HOLD_CYCLES = 20;

	logic       clk = 1'b0;
	logic       rst_n;
	logic       cmd_valid;
	logic       cmd_ready;
	logic       cmd_write;
	dev_addr_t  cmd_dev;
	word_addr_t cmd_addr;
	byte_t      cmd_wdata;
	logic       write_protect;
	logic       resp_valid;
	logic       resp_ready;
	byte_t      resp_rdata;
	logic       resp_fail;
	logic       scl;
	logic       sda_oe;
	logic       sda_in;
	logic       sda_rel;
	logic       scl_watch;      // scl must stay high while set
	integer     seed;
	byte_t      expect_mem [256];

	always #20 clk = !clk;

	assign sda_in = !sda_oe && sda_rel;   // wired-AND bus

	i2c_eeprom_master UUT (
		.clk           (clk),
		.rst_n         (rst_n),
		.cmd_valid     (cmd_valid),
		.cmd_ready     (cmd_ready),
		.cmd_write     (cmd_write),
		.cmd_dev       (cmd_dev),
		.cmd_addr      (cmd_addr),
		.cmd_wdata     (cmd_wdata),
		.write_protect (write_protect),
		.resp_valid    (resp_valid),
		.resp_ready    (resp_ready),
		.resp_rdata    (resp_rdata),
		.resp_fail     (resp_fail),
		.scl           (scl),
		.sda_oe        (sda_oe),
		.sda_in        (sda_in)
	);

	i2c_eeprom_model #(.DEV_ADDR(MODEL_DEV)) u_eeprom (
		.clk     (clk),
		.rst_n   (rst_n),
		.scl     (scl),
		.sda     (sda_in),
		.sda_rel (sda_rel)
	);

	// ****************************************
	// checking and channel helpers
	// ****************************************
	task automatic fail_stop();
		$display("Test failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check(input string name, input logic [7:0] expected, input logic [7:0] actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %s: expected %02h, actual %02h", name, expected, actual);
			fail_stop();
		end
	endtask

	always @(posedge clk)
	begin
		if (scl_watch)
			check("write_protect/scl", 8'd1, 8'(scl));
	end

	task automatic do_cmd(input logic write, input dev_addr_t dev, input word_addr_t addr,
			input byte_t wdata);
		int cycles;
		cycles = 0;
		cmd_valid <= 1'b1;
		cmd_write <= write;
		cmd_dev   <= dev;
		cmd_addr  <= addr;
		cmd_wdata <= wdata;
		@(posedge clk);
		while (!cmd_ready)
		begin
			cycles++;
			if (cycles > TIMEOUT)
			begin
				$display("cmd_ready stayed low for %0d cycles", TIMEOUT);
				fail_stop();
			end
			else
				@(posedge clk);
		end
		cmd_valid <= 1'b0;   // accepted on this edge
	endtask

	task automatic wait_resp_valid();
		int cycles;
		cycles = 0;
		@(posedge clk);
		while (!resp_valid)
		begin
			cycles++;
			if (cycles > TIMEOUT)
			begin
				$display("the DUT gave no response within %0d cycles", TIMEOUT);
				fail_stop();
			end
			else
				@(posedge clk);
		end
	endtask

	task automatic get_resp(output byte_t rdata, output logic failed);
		resp_ready <= 1'b1;
		wait_resp_valid();
		rdata = resp_rdata;
		failed = resp_fail;
		resp_ready <= 1'b0;
	endtask

	task automatic transfer(input logic write, input dev_addr_t dev, input word_addr_t addr,
			input byte_t wdata, output byte_t rdata, output logic failed);
		do_cmd(write, dev, addr, wdata);
		get_resp(rdata, failed);
	endtask

	// ****************************************
	// directed tests
	// ****************************************
	task automatic test_reset_state();
		check("reset_state/cmd_ready", 8'd1, 8'(cmd_ready));
		check("reset_state/resp_valid", 8'd0, 8'(resp_valid));
		check("reset_state/scl", 8'd1, 8'(scl));
		check("reset_state/sda_oe", 8'd0, 8'(sda_oe));
	endtask

	task automatic test_write_read_back();
		byte_t rdata;
		logic  failed;
		transfer(1'b1, MODEL_DEV, 8'h3C, 8'hA5, rdata, failed);
		expect_mem[8'h3C] = 8'hA5;
		check("write_read_back/write fail", 8'd0, 8'(failed));
		transfer(1'b0, MODEL_DEV, 8'h3C, 8'h00, rdata, failed);
		check("write_read_back/read fail", 8'd0, 8'(failed));
		check("write_read_back/read data", 8'hA5, rdata);
		transfer(1'b0, MODEL_DEV, 8'hC3, 8'h00, rdata, failed);   // never written
		check("write_read_back/fresh fail", 8'd0, 8'(failed));
		check("write_read_back/fresh data", 8'hC3, rdata);
	endtask

	task automatic test_random_sequence();
		word_addr_t addrs [8];
		byte_t      datas [8];
		byte_t      rdata;
		logic       failed;
		for (int i = 0; i < 8; i++)
		begin
			addrs[i] = word_addr_t'($random(seed));
			datas[i] = byte_t'($random(seed));
			transfer(1'b1, MODEL_DEV, addrs[i], datas[i], rdata, failed);
			expect_mem[addrs[i]] = datas[i];
			check("random_sequence/write fail", 8'd0, 8'(failed));
		end
		for (int i = 0; i < 8; i++)
		begin
			transfer(1'b0, MODEL_DEV, addrs[i], 8'h00, rdata, failed);
			check("random_sequence/read fail", 8'd0, 8'(failed));
			check("random_sequence/read data", expect_mem[addrs[i]], rdata);
		end
	endtask

	task automatic test_write_protect();
		byte_t rdata;
		logic  failed;
		write_protect <= 1'b1;
		scl_watch     <= 1'b1;
		transfer(1'b1, MODEL_DEV, 8'h3C, 8'h5A, rdata, failed);
		check("write_protect/fail", 8'd1, 8'(failed));
		repeat (2 * PHASE_DIV) @(posedge clk);
		scl_watch     <= 1'b0;
		write_protect <= 1'b0;
		transfer(1'b0, MODEL_DEV, 8'h3C, 8'h00, rdata, failed);
		check("write_protect/read fail", 8'd0, 8'(failed));
		check("write_protect/old data", expect_mem[8'h3C], rdata);
	endtask

	task automatic test_missing_device();
		byte_t rdata;
		logic  failed;
		transfer(1'b1, MISSING_DEV, 8'h10, 8'h77, rdata, failed);
		check("missing_device/write fail", 8'd1, 8'(failed));
		check("missing_device/scl after write", 8'd1, 8'(scl));
		check("missing_device/sda_oe after write", 8'd0, 8'(sda_oe));
		transfer(1'b0, MISSING_DEV, 8'h10, 8'h00, rdata, failed);
		check("missing_device/read fail", 8'd1, 8'(failed));
		check("missing_device/scl after read", 8'd1, 8'(scl));
		check("missing_device/sda_oe after read", 8'd0, 8'(sda_oe));
		transfer(1'b0, MODEL_DEV, 8'h10, 8'h00, rdata, failed);
		check("missing_device/recovery fail", 8'd0, 8'(failed));
		check("missing_device/recovery data", expect_mem[8'h10], rdata);
	endtask

	task automatic test_back_pressure();
		byte_t rdata;
		logic  failed;
		do_cmd(1'b0, MODEL_DEV, 8'h3C, 8'h00);
		wait_resp_valid();                  // resp_ready still low
		repeat (HOLD_CYCLES)
		begin
			@(posedge clk);
			check("back_pressure/resp_valid", 8'd1, 8'(resp_valid));
			check("back_pressure/resp_rdata", expect_mem[8'h3C], resp_rdata);
			check("back_pressure/resp_fail", 8'd0, 8'(resp_fail));
			check("back_pressure/cmd_ready", 8'd0, 8'(cmd_ready));
		end
		get_resp(rdata, failed);
		check("back_pressure/fail", 8'd0, 8'(failed));
		check("back_pressure/data", expect_mem[8'h3C], rdata);
		@(posedge clk);
		check("back_pressure/cmd_ready after", 8'd1, 8'(cmd_ready));
	endtask

	initial
	begin
		rst_n         = 1'b0;
		cmd_valid     = 1'b0;
		cmd_write     = 1'b0;
		cmd_dev       = '0;
		cmd_addr      = '0;
		cmd_wdata     = '0;
		write_protect = 1'b0;
		resp_ready    = 1'b0;
		scl_watch     = 1'b0;
		seed          = 32'hf4effa44;
		for (int i = 0; i < 256; i++)
			expect_mem[i] = byte_t'(i);
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		test_reset_state();
		test_write_read_back();
		test_random_sequence();
		test_write_protect();
		test_missing_device();
		test_back_pressure();
		$display("Test passed");
		$finish;
	end

endmodule

// ==== build.f ====
logic/i2c_pkg.sv
logic/i2c_phase_timer.sv
logic/i2c_cmd_ctrl.sv
logic/i2c_bus_fsm.sv
logic/i2c_eeprom_master.sv
test/i2c_eeprom_model.sv
test/tb_i2c_eeprom_master.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and judges the log

rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_i2c_eeprom_master -f build.f -o sim_tb \
	&& ./obj_dir/sim_tb 2>&1 | tee sim.log \
	|| { echo "build or simulation did not run"; exit 1; }
grep -q "Test failed" sim.log && exit 1 || exit 0
